//--- common/qamPkg.sv
package qamPkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------
	localparam int PAYLOAD_BITS = 16;
	localparam int SYMBOL_BITS = 4;
	localparam int SYMBOLS_PER_WORD = 4;
	localparam int SYMBOL_IDX_BITS = $clog2(SYMBOLS_PER_WORD);

	// one carrier period is 256 phase steps, one symbol lasts one period
	localparam int PHASE_BITS = 8;
	// quarter period, also the cosine offset
	localparam int QUARTER_STEPS = 64;

	localparam int LEVEL_BITS = 4;
	localparam int SINE_BITS = 16;
	localparam int SAMPLE_BITS = 19;
	localparam int SINE_AMPLITUDE = 32767;

	// ----------------------------------------------------------------------
	// wishbone register map
	// ----------------------------------------------------------------------
	localparam int WB_ADDR_BITS = 2;
	localparam int WB_DATA_BITS = 32;
	localparam logic [WB_ADDR_BITS-1:0] ADDR_PAYLOAD = 2'd0;
	// bit 0 is enable
	localparam logic [WB_ADDR_BITS-1:0] ADDR_CONTROL = 2'd1;

	// ----------------------------------------------------------------------
	// types
	// ----------------------------------------------------------------------
	typedef logic signed [LEVEL_BITS-1:0] levelT;
	typedef logic signed [SINE_BITS-1:0] sineT;
	typedef logic signed [SAMPLE_BITS-1:0] sampleT;

	// big selects magnitude 2 over 1, neg flips the sign
	typedef struct packed {
		logic qNeg;
		logic iNeg;
		logic qBig;
		logic iBig;
	} symbolFields;

	// nibble as taken from the payload, or split into its level fields
	typedef union packed {
		logic [SYMBOL_BITS-1:0] raw;
		symbolFields fields;
	} symbolWord;

endpackage

//--- rtl/qamRegs.sv
module qamRegs (
	input logic CLOCK_50,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [qamPkg::WB_ADDR_BITS-1:0] wbAdr,
	input logic [qamPkg::WB_DATA_BITS-1:0] wbDatW,
	output logic [qamPkg::WB_DATA_BITS-1:0] wbDatR,
	output logic wbAck,
	output logic [qamPkg::PAYLOAD_BITS-1:0] payload,
	output logic enable
);

	// new access seen, ack not yet given
	logic accessStart;

	assign accessStart = wbCyc && wbStb && !wbAck;

	// ----------------------------------------------------------------------
	// ack and register writes
	// ----------------------------------------------------------------------
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			wbAck <= 1'b0;
			payload <= '0;
			enable <= 1'b0;
		end else begin
			wbAck <= accessStart;
			// write lands on the same edge that raises ack
			if (accessStart && wbWe) begin
				case (wbAdr)
					qamPkg::ADDR_PAYLOAD: begin
						payload <= wbDatW[qamPkg::PAYLOAD_BITS-1:0];
					end
					qamPkg::ADDR_CONTROL: begin
						enable <= wbDatW[0];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ----------------------------------------------------------------------
	// read mux
	// ----------------------------------------------------------------------
	// address is held by the master until ack, so a plain decode is enough
	always_comb begin
		case (wbAdr)
			qamPkg::ADDR_PAYLOAD: begin
				wbDatR = {{(qamPkg::WB_DATA_BITS - qamPkg::PAYLOAD_BITS){1'b0}}, payload};
			end
			qamPkg::ADDR_CONTROL: begin
				wbDatR = {{(qamPkg::WB_DATA_BITS - 1){1'b0}}, enable};
			end
			default: begin
				// unmapped
				wbDatR = '0;
			end
		endcase
	end

	// one ack per access, never stretched
	ackSinglePulse: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		wbAck |=> !wbAck
	);

endmodule

//--- modulator/symbolSequencer.sv
module symbolSequencer (
	input logic CLOCK_50,
	input logic rst,
	input logic [qamPkg::PAYLOAD_BITS-1:0] payload,
	input logic enable,
	output logic [qamPkg::PHASE_BITS-1:0] phase,
	output qamPkg::levelT iLevel,
	output qamPkg::levelT qLevel,
	output logic levelValid
);

	logic running;
	logic [qamPkg::SYMBOL_IDX_BITS-1:0] symIdx;
	logic [qamPkg::PAYLOAD_BITS-1:0] shadow;
	qamPkg::symbolWord nib;

	// magnitude 1 or 2, then sign
	function automatic qamPkg::levelT toLevel(input logic big, input logic neg);
		qamPkg::levelT mag;
		mag = big ? 4'sd2 : 4'sd1;
		return neg ? -mag : mag;
	endfunction

	// ----------------------------------------------------------------------
	// phase and symbol counters
	// ----------------------------------------------------------------------
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			running <= 1'b0;
			phase <= '0;
			symIdx <= '0;
			shadow <= '0;
		end else if (!enable) begin
			running <= 1'b0;
			phase <= '0;
			symIdx <= '0;
		end else if (!running) begin
			// first enabled cycle starts a frame
			running <= 1'b1;
			shadow <= payload;
		end else begin
			phase <= phase + 1'b1;
			if (phase == '1) begin
				symIdx <= symIdx + 1'b1;
				// last symbol done, pick up the next word
				if (symIdx == '1) begin
					shadow <= payload;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// level mapping
	// ----------------------------------------------------------------------
	// low nibble goes out first
	assign nib.raw = shadow[symIdx*qamPkg::SYMBOL_BITS +: qamPkg::SYMBOL_BITS];

	assign iLevel = toLevel(nib.fields.iBig, nib.fields.iNeg);
	assign qLevel = toLevel(nib.fields.qBig, nib.fields.qNeg);
	assign levelValid = running && enable;

	// symbols only step at the end of a carrier period or on disable
	symbolStepsOnWrap: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		(symIdx != $past(symIdx)) |->
			($past(phase) == '1) || !$past(enable) || $past(rst)
	);

endmodule

//--- modulator/sineLut.sv
module sineLut (
	input logic CLOCK_50,
	input logic [qamPkg::PHASE_BITS-1:0] phase,
	output qamPkg::sineT value
);

	// quadrant and offset within it
	logic [1:0] quadrant;
	logic [qamPkg::PHASE_BITS-3:0] offset;
	logic [qamPkg::PHASE_BITS-2:0] idx;
	qamPkg::sineT mag;

	assign quadrant = phase[qamPkg::PHASE_BITS-1 -: 2];
	assign offset = phase[qamPkg::PHASE_BITS-3:0];

	// quadrants 1 and 3 run the table backwards
	assign idx = quadrant[0] ?
		(qamPkg::PHASE_BITS - 1)'(qamPkg::QUARTER_STEPS) - {1'b0, offset} :
		{1'b0, offset};

	// ----------------------------------------------------------------------
	// first quadrant, round(amplitude * sin(2*pi*k/256))
	// ----------------------------------------------------------------------
	always_comb begin
		case (idx)
			7'd0: mag = 16'sd0;
			7'd1: mag = 16'sd804;
			7'd2: mag = 16'sd1608;
			7'd3: mag = 16'sd2410;
			7'd4: mag = 16'sd3212;
			7'd5: mag = 16'sd4011;
			7'd6: mag = 16'sd4808;
			7'd7: mag = 16'sd5602;
			7'd8: mag = 16'sd6393;
			7'd9: mag = 16'sd7179;
			7'd10: mag = 16'sd7962;
			7'd11: mag = 16'sd8739;
			7'd12: mag = 16'sd9512;
			7'd13: mag = 16'sd10278;
			7'd14: mag = 16'sd11039;
			7'd15: mag = 16'sd11793;
			7'd16: mag = 16'sd12539;
			7'd17: mag = 16'sd13279;
			7'd18: mag = 16'sd14010;
			7'd19: mag = 16'sd14732;
			7'd20: mag = 16'sd15446;
			7'd21: mag = 16'sd16151;
			7'd22: mag = 16'sd16846;
			7'd23: mag = 16'sd17530;
			7'd24: mag = 16'sd18204;
			7'd25: mag = 16'sd18868;
			7'd26: mag = 16'sd19519;
			7'd27: mag = 16'sd20159;
			7'd28: mag = 16'sd20787;
			7'd29: mag = 16'sd21403;
			7'd30: mag = 16'sd22005;
			7'd31: mag = 16'sd22594;
			7'd32: mag = 16'sd23170;
			7'd33: mag = 16'sd23731;
			7'd34: mag = 16'sd24279;
			7'd35: mag = 16'sd24811;
			7'd36: mag = 16'sd25329;
			7'd37: mag = 16'sd25832;
			7'd38: mag = 16'sd26319;
			7'd39: mag = 16'sd26790;
			7'd40: mag = 16'sd27245;
			7'd41: mag = 16'sd27683;
			7'd42: mag = 16'sd28105;
			7'd43: mag = 16'sd28510;
			7'd44: mag = 16'sd28898;
			7'd45: mag = 16'sd29268;
			7'd46: mag = 16'sd29621;
			7'd47: mag = 16'sd29956;
			7'd48: mag = 16'sd30273;
			7'd49: mag = 16'sd30571;
			7'd50: mag = 16'sd30852;
			7'd51: mag = 16'sd31113;
			7'd52: mag = 16'sd31356;
			7'd53: mag = 16'sd31580;
			7'd54: mag = 16'sd31785;
			7'd55: mag = 16'sd31971;
			7'd56: mag = 16'sd32137;
			7'd57: mag = 16'sd32285;
			7'd58: mag = 16'sd32412;
			7'd59: mag = 16'sd32521;
			7'd60: mag = 16'sd32609;
			7'd61: mag = 16'sd32678;
			7'd62: mag = 16'sd32728;
			7'd63: mag = 16'sd32757;
			// peak, only reached from a mirrored quadrant
			default: mag = qamPkg::sineT'(qamPkg::SINE_AMPLITUDE);
		endcase
	end

	// second half of the period is the negative lobe
	always_ff @(posedge CLOCK_50) begin
		value <= quadrant[1] ? -mag : mag;
	end

endmodule

//--- modulator/iqMixer.sv
module iqMixer (
	input logic CLOCK_50,
	input logic rst,
	input logic [qamPkg::PHASE_BITS-1:0] phase,
	input qamPkg::levelT iLevel,
	input qamPkg::levelT qLevel,
	input logic levelValid,
	output qamPkg::sampleT sample,
	output qamPkg::levelT iOut,
	output qamPkg::levelT qOut,
	output logic sampleValid
);

	logic [qamPkg::PHASE_BITS-1:0] cosPhase;
	qamPkg::sineT sinVal;
	qamPkg::sineT cosVal;

	// levels lined up with the table output
	qamPkg::levelT iDly;
	qamPkg::levelT qDly;
	logic validDly;

	qamPkg::sampleT iProd;
	qamPkg::sampleT qProd;

	// cos(x) is sin(x + quarter period)
	assign cosPhase = phase + (qamPkg::PHASE_BITS)'(qamPkg::QUARTER_STEPS);

	sineLut u_sin (
		.CLOCK_50 (CLOCK_50),
		.phase    (phase),
		.value    (sinVal)
	);

	sineLut u_cos (
		.CLOCK_50 (CLOCK_50),
		.phase    (cosPhase),
		.value    (cosVal)
	);

	// ----------------------------------------------------------------------
	// stage 1 level delay, stage 2 multiply and subtract
	// ----------------------------------------------------------------------
	assign iProd = iDly * cosVal;
	assign qProd = qDly * sinVal;

	always_ff @(posedge CLOCK_50) begin
		iDly <= iLevel;
		qDly <= qLevel;
		if (rst) begin
			validDly <= 1'b0;
			sampleValid <= 1'b0;
			sample <= '0;
			iOut <= '0;
			qOut <= '0;
		end else begin
			validDly <= levelValid;
			sampleValid <= validDly;
			iOut <= iDly;
			qOut <= qDly;
			// idle output sits at zero
			sample <= validDly ? iProd - qProd : '0;
		end
	end

	idleSampleZero: assert property (
		@(posedge CLOCK_50) disable iff (rst)
		!sampleValid |-> (sample == '0)
	);

endmodule

//--- rtl/qamModulator.sv
module qamModulator (
	input logic CLOCK_50,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [qamPkg::WB_ADDR_BITS-1:0] wbAdr,
	input logic [qamPkg::WB_DATA_BITS-1:0] wbDatW,
	output logic [qamPkg::WB_DATA_BITS-1:0] wbDatR,
	output logic wbAck,
	output qamPkg::sampleT sample,
	output qamPkg::levelT iOut,
	output qamPkg::levelT qOut,
	output logic sampleValid
);

	logic [qamPkg::PAYLOAD_BITS-1:0] payload;
	logic enable;

	logic [qamPkg::PHASE_BITS-1:0] phase;
	qamPkg::levelT iLevel;
	qamPkg::levelT qLevel;
	logic levelValid;

	// bus side
	qamRegs u_regs (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.wbCyc    (wbCyc),
		.wbStb    (wbStb),
		.wbWe     (wbWe),
		.wbAdr    (wbAdr),
		.wbDatW   (wbDatW),
		.wbDatR   (wbDatR),
		.wbAck    (wbAck),
		.payload  (payload),
		.enable   (enable)
	);

	// ----------------------------------------------------------------------
	// modulator datapath
	// ----------------------------------------------------------------------
	symbolSequencer u_seq (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.payload    (payload),
		.enable     (enable),
		.phase      (phase),
		.iLevel     (iLevel),
		.qLevel     (qLevel),
		.levelValid (levelValid)
	);

	iqMixer u_mix (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.phase       (phase),
		.iLevel      (iLevel),
		.qLevel      (qLevel),
		.levelValid  (levelValid),
		.sample      (sample),
		.iOut        (iOut),
		.qOut        (qOut),
		.sampleValid (sampleValid)
	);

endmodule

//--- testbench/wbTasks.svh
`ifndef WB_TASKS_SVH
`define WB_TASKS_SVH

// longest wait for an acknowledge before the access is given up
localparam int ACK_LIMIT = 16;

// holds the request until ack, then releases the bus
task automatic waitAck(input logic [qamPkg::WB_ADDR_BITS-1:0] addr);
	int waited;
	waited = 0;
	@(posedge CLOCK_50);
	while (!wbAck && waited < ACK_LIMIT) begin
		@(posedge CLOCK_50);
		waited++;
	end
	if (!wbAck) begin
		errorCount++;
		$display("bus access to address %0d was never acknowledged", addr);
	end
	wbCyc <= 1'b0;
	wbStb <= 1'b0;
	wbWe <= 1'b0;
	readCheck <= 1'b0;
endtask

// single classic write cycle
task automatic busWrite(
	input logic [qamPkg::WB_ADDR_BITS-1:0] addr,
	input logic [qamPkg::WB_DATA_BITS-1:0] data
);
	@(posedge CLOCK_50);
	wbCyc <= 1'b1;
	wbStb <= 1'b1;
	wbWe <= 1'b1;
	wbAdr <= addr;
	wbDatW <= data;
	waitAck(addr);
endtask

// single classic read cycle, data is checked on the ack cycle
task automatic busRead(
	input logic [qamPkg::WB_ADDR_BITS-1:0] addr,
	input logic [qamPkg::WB_DATA_BITS-1:0] expected
);
	@(posedge CLOCK_50);
	wbCyc <= 1'b1;
	wbStb <= 1'b1;
	wbWe <= 1'b0;
	wbAdr <= addr;
	readCheck <= 1'b1;
	expRead <= expected;
	waitAck(addr);
endtask

`endif

//--- testbench/qamModulatorTb.sv
module qamModulatorTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PERIOD_STEPS = 1 << qamPkg::PHASE_BITS;
	localparam int FRAME_SAMPLES = qamPkg::SYMBOLS_PER_WORD * PERIOD_STEPS;
	// six frames plus bus traffic and idle gaps
	localparam int CYCLE_LIMIT = 12000;
	localparam real PI = 3.14159265358979;

	logic CLOCK_50;
	logic rst;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [qamPkg::WB_ADDR_BITS-1:0] wbAdr;
	logic [qamPkg::WB_DATA_BITS-1:0] wbDatW;
	logic [qamPkg::WB_DATA_BITS-1:0] wbDatR;
	logic wbAck;
	qamPkg::sampleT sample;
	qamPkg::levelT iOut;
	qamPkg::levelT qOut;
	logic sampleValid;

	int seed;
	int errorCount;
	int errorsBefore;
	int testCount;
	int testsFailed;
	int cycleCount;
	// reference model state
	int kCount;
	int validCount;
	logic [qamPkg::PAYLOAD_BITS-1:0] modelPayload;
	logic [qamPkg::PAYLOAD_BITS-1:0] frameWord;
	logic [qamPkg::PAYLOAD_BITS-1:0] firstWord;
	logic [qamPkg::PAYLOAD_BITS-1:0] secondWord;
	logic idleWindow;
	logic quietWindow;
	logic readCheck;
	logic [qamPkg::WB_DATA_BITS-1:0] expRead;

	`include "wbTasks.svh"

	qamModulator u_dut (
		.CLOCK_50    (CLOCK_50),
		.rst         (rst),
		.wbCyc       (wbCyc),
		.wbStb       (wbStb),
		.wbWe        (wbWe),
		.wbAdr       (wbAdr),
		.wbDatW      (wbDatW),
		.wbDatR      (wbDatR),
		.wbAck       (wbAck),
		.sample      (sample),
		.iOut        (iOut),
		.qOut        (qOut),
		.sampleValid (sampleValid)
	);

	always #2 CLOCK_50 = ~CLOCK_50;

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	// round half away from zero
	function automatic int roundScaled(input real x);
		real scaled;
		scaled = x * qamPkg::SINE_AMPLITUDE;
		if (scaled >= 0.0) begin
			return $rtoi(scaled + 0.5);
		end
		return -$rtoi(0.5 - scaled);
	endfunction

	function automatic int levelFor(input logic big, input logic neg);
		int mag;
		mag = big ? 2 : 1;
		return neg ? -mag : mag;
	endfunction

	// symbols go out low nibble first, one per carrier period
	function automatic logic [3:0] nibbleAt(input int k, input logic [15:0] word);
		int symbol;
		symbol = (k / PERIOD_STEPS) % qamPkg::SYMBOLS_PER_WORD;
		return word[4 * symbol +: 4];
	endfunction

	function automatic int expectedI(input int k, input logic [15:0] word);
		logic [3:0] nib;
		nib = nibbleAt(k, word);
		return levelFor(nib[0], nib[2]);
	endfunction

	function automatic int expectedQ(input int k, input logic [15:0] word);
		logic [3:0] nib;
		nib = nibbleAt(k, word);
		return levelFor(nib[1], nib[3]);
	endfunction

	function automatic int expectedSample(input int k, input logic [15:0] word);
		real angle;
		angle = 2.0 * PI * (k % PERIOD_STEPS) / PERIOD_STEPS;
		return expectedI(k, word) * roundScaled($cos(angle)) -
			expectedQ(k, word) * roundScaled($sin(angle));
	endfunction

	// k restarts whenever the output goes idle, word is picked per frame
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			kCount <= 0;
			validCount <= 0;
			frameWord <= '0;
		end else if (sampleValid) begin
			kCount <= kCount + 1;
			validCount <= validCount + 1;
			if (kCount % FRAME_SAMPLES == FRAME_SAMPLES - 1) begin
				frameWord <= modelPayload;
			end
		end else begin
			kCount <= 0;
			frameWord <= modelPayload;
		end
	end

	always @(posedge CLOCK_50) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	idleAck: assert property (@(posedge CLOCK_50) disable iff (rst) idleWindow |-> !wbAck)
		else begin
			errorCount++;
			$display("FAILED at %0t: wbAck expected 0, actual %0b", $time, $sampled(wbAck));
		end

	idleSample: assert property (@(posedge CLOCK_50) disable iff (rst)
		idleWindow |-> (sample == '0))
		else begin
			errorCount++;
			$display("FAILED at %0t: sample expected 0, actual %0d", $time, $sampled(sample));
		end

	// idle after reset and after a disable
	outputQuiet: assert property (@(posedge CLOCK_50) disable iff (rst)
		(idleWindow || quietWindow) |-> !sampleValid)
		else begin
			errorCount++;
			$display("FAILED at %0t: sampleValid expected 0, actual %0b", $time,
				$sampled(sampleValid));
		end

	ackFollowsRequest: assert property (@(posedge CLOCK_50) disable iff (rst)
		(wbCyc && wbStb && !wbAck) |=> wbAck)
		else begin
			errorCount++;
			$display("no acknowledge in the cycle after a bus request at %0t", $time);
		end

	ackOnce: assert property (@(posedge CLOCK_50) disable iff (rst) wbAck |=> !wbAck)
		else begin
			errorCount++;
			$display("acknowledge stayed high for two cycles at %0t", $time);
		end

	readData: assert property (@(posedge CLOCK_50) disable iff (rst)
		(readCheck && wbAck) |-> (wbDatR == expRead))
		else begin
			errorCount++;
			$display("FAILED at %0t: wbDatR expected 0x%08h, actual 0x%08h", $time,
				$sampled(expRead), $sampled(wbDatR));
		end

	levelI: assert property (@(posedge CLOCK_50) disable iff (rst)
		sampleValid |-> (iOut == expectedI(kCount, frameWord)))
		else begin
			errorCount++;
			$display("FAILED at %0t: iOut expected %0d, actual %0d", $time,
				expectedI($sampled(kCount), $sampled(frameWord)), $sampled(iOut));
		end

	levelQ: assert property (@(posedge CLOCK_50) disable iff (rst)
		sampleValid |-> (qOut == expectedQ(kCount, frameWord)))
		else begin
			errorCount++;
			$display("FAILED at %0t: qOut expected %0d, actual %0d", $time,
				expectedQ($sampled(kCount), $sampled(frameWord)), $sampled(qOut));
		end

	sampleValue: assert property (@(posedge CLOCK_50) disable iff (rst)
		sampleValid |-> (sample == expectedSample(kCount, frameWord)))
		else begin
			errorCount++;
			$display("FAILED at %0t: sample expected %0d, actual %0d", $time,
				expectedSample($sampled(kCount), $sampled(frameWord)), $sampled(sample));
		end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic writePayload(input logic [qamPkg::PAYLOAD_BITS-1:0] word);
		busWrite(qamPkg::ADDR_PAYLOAD, (qamPkg::WB_DATA_BITS)'(word));
		modelPayload <= word;
	endtask

	// returns once n more valid samples have been seen
	task automatic waitSamples(input int n);
		int target;
		target = validCount + n;
		while (validCount < target) begin
			@(posedge CLOCK_50);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount > errorsBefore) begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end else begin
			$display("test %0d %s: ok", testCount, name);
		end
		errorsBefore = errorCount;
	endtask

	initial begin
		CLOCK_50 = 1'b0;
		rst = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		seed = 12;
		errorCount = 0;
		errorsBefore = 0;
		testCount = 0;
		testsFailed = 0;
		cycleCount = 0;
		modelPayload = '0;
		idleWindow = 1'b0;
		quietWindow = 1'b0;
		readCheck = 1'b0;
		expRead = '0;

		repeat (10) @(posedge CLOCK_50);
		rst <= 1'b0;

		idleWindow <= 1'b1;
		repeat (20) @(posedge CLOCK_50);
		idleWindow <= 1'b0;
		endTest("idle after reset");

		writePayload(16'h5a3c);
		busRead(qamPkg::ADDR_PAYLOAD, 32'h0000_5a3c);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0001);
		busRead(qamPkg::ADDR_CONTROL, 32'h0000_0001);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0000);
		busRead(qamPkg::ADDR_CONTROL, 32'h0000_0000);
		busRead(2'd2, '0);
		busRead(2'd3, '0);
		endTest("register readback");

		firstWord = 16'($random(seed));
		writePayload(firstWord);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0001);
		waitSamples(FRAME_SAMPLES);
		endTest("symbol mapping");

		// same word again, all four quadrants per symbol
		waitSamples(FRAME_SAMPLES);
		endTest("waveform");

		secondWord = 16'($random(seed));
		// upper two symbols play after the write, they must differ
		if (secondWord[15:8] == firstWord[15:8]) begin
			secondWord[15:8] = ~secondWord[15:8];
		end
		waitSamples(FRAME_SAMPLES / 2);
		writePayload(secondWord);
		waitSamples(FRAME_SAMPLES / 2 + FRAME_SAMPLES);
		endTest("payload update at frame boundary");

		// stop in the middle of the second symbol
		waitSamples(PERIOD_STEPS + PERIOD_STEPS / 2);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0000);
		// two stage pipeline drains
		repeat (2) @(posedge CLOCK_50);
		quietWindow <= 1'b1;
		repeat (40) @(posedge CLOCK_50);
		quietWindow <= 1'b0;
		// four different nibbles, so a wrong restart symbol shows
		writePayload(16'h93c6);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0001);
		waitSamples(FRAME_SAMPLES / 2);
		busWrite(qamPkg::ADDR_CONTROL, 32'h0000_0000);
		endTest("disable and restart");

		$display("tests: %0d, failed: %0d, errors: %0d", testCount, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+testbench
common/qamPkg.sv
rtl/qamRegs.sv
modulator/symbolSequencer.sv
modulator/sineLut.sv
modulator/iqMixer.sv
rtl/qamModulator.sv
testbench/qamModulatorTb.sv

//--- Bender.yml
package:
  name: qam_modulator

sources:
  - files:
      - common/qamPkg.sv
      - rtl/qamRegs.sv
      - modulator/symbolSequencer.sv
      - modulator/sineLut.sv
      - modulator/iqMixer.sv
      - rtl/qamModulator.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/qamModulatorTb.sv
